/* all.f */
rtl/capture_pkg.sv
rtl/frame_store.sv
rtl/store_arbiter.sv
rtl/pixel_writer.sv
rtl/frame_reader.sv
rtl/uart_cmd_rx.sv
rtl/frame_capture_top.sv
verif/tb_frame_capture.sv

/* rtl/capture_pkg.sv */
// Shared definitions for the frame capture core.
// Frame geometry, UART bit timing, command bytes,
// vector types and the state encodings of the FSMs.
`default_nettype none

package capture_pkg;

    // frame geometry.
    localparam int frame_width  = 8;
    localparam int frame_height = 4;
    localparam int frame_pixels = frame_width * frame_height;

    // one pixel is red, green, blue from the top byte down.
    typedef logic [23:0] pixel_t;
    typedef logic [4:0]  addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [10:0] bit_cnt_t;

    // 125 MHz clock at 115200 bps.
    localparam bit_cnt_t clks_per_bit = 11'd1085;

    // ascii 'C' and 'R'.
    localparam byte_t cmd_capture = 8'h43;
    localparam byte_t cmd_readout = 8'h52;

    typedef enum logic [1:0] {
        writer_idle,
        writer_armed,
        writer_writing
    } writer_state_t;

    typedef enum logic [1:0] {
        reader_idle,
        reader_request,
        reader_wait_data,
        reader_send
    } reader_state_t;

    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

endpackage

`default_nettype wire

/* rtl/frame_capture_top.sv */
// Frame capture top level.
// Command receiver, pixel writer, frame reader and the
// arbitrated frame store, all on one clock.
`default_nettype none

module frame_capture_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                uart_rxd,
    input  wire logic                vsync,
    input  wire logic                de,
    input  wire capture_pkg::pixel_t pixel,
    input  wire logic                tx_ready,
    output logic                     tx_valid,
    output capture_pkg::byte_t       tx_byte,
    output logic                     tx_last,
    output logic                     frame_ready
);

    logic                capture_cmd;
    logic                readout_cmd;
    logic                wr_req;
    capture_pkg::addr_t  wr_addr;
    capture_pkg::pixel_t wr_pixel;
    logic                rd_req;
    capture_pkg::addr_t  rd_addr;
    logic                rd_gnt;
    capture_pkg::pixel_t rd_data;

    uart_cmd_rx uart_rx0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rxd    (uart_rxd),
        .capture_cmd (capture_cmd),
        .readout_cmd (readout_cmd)
    );

    pixel_writer writer0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture_cmd (capture_cmd),
        .vsync       (vsync),
        .de          (de),
        .pixel       (pixel),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_pixel    (wr_pixel),
        .frame_ready (frame_ready)
    );

    frame_reader reader0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .readout_cmd (readout_cmd),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_gnt      (rd_gnt),
        .rd_data     (rd_data),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_last     (tx_last),
        .tx_ready    (tx_ready)
    );

    store_arbiter arbiter0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_gnt   (rd_gnt),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/frame_reader.sv */
// Frame readout as a byte stream.
// Reads each stored pixel through the arbiter and sends it as
// red, green and blue bytes with ready/valid and a last flag.
`default_nettype none

module frame_reader (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                readout_cmd,
    output logic                     rd_req,
    output capture_pkg::addr_t       rd_addr,
    input  wire logic                rd_gnt,
    input  wire capture_pkg::pixel_t rd_data,
    output logic                     tx_valid,
    output capture_pkg::byte_t       tx_byte,
    output logic                     tx_last,
    input  wire logic                tx_ready
);

    capture_pkg::reader_state_t state;
    capture_pkg::pixel_t        pix_q;
    logic [1:0]                 byte_sel;
    logic                       last_pixel;

    assign last_pixel = rd_addr == capture_pkg::addr_t'(capture_pkg::frame_pixels - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= capture_pkg::reader_idle;
            rd_req   <= 1'b0;
            rd_addr  <= '0;
            tx_valid <= 1'b0;
            byte_sel <= 2'd0;
        end else begin
            case (state)
                capture_pkg::reader_idle: begin
                    if (readout_cmd) begin
                        rd_addr <= '0;
                        rd_req  <= 1'b1;
                        state   <= capture_pkg::reader_request;
                    end
                end
                capture_pkg::reader_request: begin
                    // address is held until the writer leaves a free cycle.
                    if (rd_gnt) begin
                        rd_req <= 1'b0;
                        state  <= capture_pkg::reader_wait_data;
                    end
                end
                capture_pkg::reader_wait_data: begin
                    byte_sel <= 2'd0;
                    tx_valid <= 1'b1;
                    state    <= capture_pkg::reader_send;
                end
                capture_pkg::reader_send: begin
                    if (tx_ready) begin
                        if (byte_sel == 2'd2) begin
                            tx_valid <= 1'b0;
                            if (last_pixel) begin
                                state <= capture_pkg::reader_idle;
                            end else begin
                                rd_addr <= rd_addr + 1'b1;
                                rd_req  <= 1'b1;
                                state   <= capture_pkg::reader_request;
                            end
                        end else begin
                            byte_sel <= byte_sel + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= capture_pkg::reader_idle;
                end
            endcase
        end
    end

    // store data is valid in the cycle after the grant.
    always_ff @(posedge clk) begin
        if (state == capture_pkg::reader_wait_data) begin
            pix_q <= rd_data;
        end
    end

    always_comb begin
        case (byte_sel)
            2'd0:    tx_byte = pix_q[23:16];
            2'd1:    tx_byte = pix_q[15:8];
            default: tx_byte = pix_q[7:0];
        endcase
    end

    assign tx_last = tx_valid && last_pixel && byte_sel == 2'd2;

endmodule

`default_nettype wire

/* rtl/frame_store.sv */
// Single-port frame memory.
// One pixel word per address, read data is registered.
`default_nettype none

module frame_store (
    input  wire logic                clk,
    input  wire logic                en,
    input  wire logic                we,
    input  wire capture_pkg::addr_t  addr,
    input  wire capture_pkg::pixel_t wdata,
    output capture_pkg::pixel_t      rdata
);

    capture_pkg::pixel_t mem [0:capture_pkg::frame_pixels-1];

    // a read and a write never share a cycle on the single port.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pixel_writer.sv */
// Pixel writer for one captured frame.
// Arms on a capture command, starts on the next vsync rising edge
// and writes each active pixel to the next store address.
`default_nettype none

module pixel_writer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                capture_cmd,
    input  wire logic                vsync,
    input  wire logic                de,
    input  wire capture_pkg::pixel_t pixel,
    output logic                     wr_req,
    output capture_pkg::addr_t       wr_addr,
    output capture_pkg::pixel_t      wr_pixel,
    output logic                     frame_ready
);

    capture_pkg::writer_state_t state;
    capture_pkg::addr_t         pix_cnt;
    logic                       vsync_q;
    logic                       vsync_rise;

    assign vsync_rise = vsync && !vsync_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= capture_pkg::writer_idle;
            pix_cnt     <= '0;
            vsync_q     <= 1'b0;
            wr_req      <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            vsync_q <= vsync;
            wr_req  <= 1'b0;
            // the last write lands on this edge.
            if (wr_req && wr_addr == capture_pkg::addr_t'(capture_pkg::frame_pixels - 1)) begin
                frame_ready <= 1'b1;
            end
            case (state)
                capture_pkg::writer_idle: begin
                    if (capture_cmd) begin
                        frame_ready <= 1'b0;
                        state       <= capture_pkg::writer_armed;
                    end
                end
                capture_pkg::writer_armed: begin
                    if (vsync_rise) begin
                        pix_cnt <= '0;
                        state   <= capture_pkg::writer_writing;
                    end
                end
                capture_pkg::writer_writing: begin
                    // further vsync edges are ignored until the frame is full.
                    if (de) begin
                        wr_req  <= 1'b1;
                        pix_cnt <= pix_cnt + 1'b1;
                        if (pix_cnt == capture_pkg::addr_t'(capture_pkg::frame_pixels - 1)) begin
                            state <= capture_pkg::writer_idle;
                        end
                    end
                end
                default: begin
                    state <= capture_pkg::writer_idle;
                end
            endcase
        end
    end

    // address and pixel for the write request.
    always_ff @(posedge clk) begin
        if (state == capture_pkg::writer_writing && de) begin
            wr_addr  <= pix_cnt;
            wr_pixel <= pixel;
        end
    end

endmodule

`default_nettype wire

/* rtl/store_arbiter.sv */
// Fixed-priority access to the frame store.
// The pixel writer always wins, the frame reader gets idle cycles.
// Holds the frame store instance.
`default_nettype none

module store_arbiter (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                wr_req,
    input  wire capture_pkg::addr_t  wr_addr,
    input  wire capture_pkg::pixel_t wr_pixel,
    input  wire logic                rd_req,
    input  wire capture_pkg::addr_t  rd_addr,
    output logic                     rd_gnt,
    output capture_pkg::pixel_t      rd_data
);

    logic                store_en;
    logic                store_we;
    capture_pkg::addr_t  store_addr;
    capture_pkg::pixel_t store_wdata;
    logic                rd_busy;

    // only one read in flight while its data returns.
    assign rd_gnt = rd_req && !wr_req && !rd_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
        end else begin
            rd_busy <= rd_gnt;
        end
    end

    // route the winning port to the store.
    always_comb begin
        store_en    = wr_req || rd_gnt;
        store_we    = wr_req;
        store_addr  = wr_req ? wr_addr : rd_addr;
        store_wdata = wr_pixel;
    end

    frame_store store0 (
        .clk   (clk),
        .en    (store_en),
        .we    (store_we),
        .addr  (store_addr),
        .wdata (store_wdata),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/uart_cmd_rx.sv */
// UART 8N1 command receiver.
// Synchronizes the line, samples each bit in its middle and
// decodes the capture and readout command bytes into pulses.
`default_nettype none

module uart_cmd_rx (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic uart_rxd,
    output logic      capture_cmd,
    output logic      readout_cmd
);

    capture_pkg::uart_state_t state;
    capture_pkg::bit_cnt_t    timer;
    capture_pkg::byte_t       shreg;
    logic [2:0]               bit_idx;
    logic                     rxd_meta;
    logic                     rxd_sync;
    logic                     bit_end;

    // two-flop synchronizer, line idles high.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign bit_end = timer == capture_pkg::clks_per_bit - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= capture_pkg::uart_idle;
            timer       <= '0;
            bit_idx     <= 3'd0;
            capture_cmd <= 1'b0;
            readout_cmd <= 1'b0;
        end else begin
            capture_cmd <= 1'b0;
            readout_cmd <= 1'b0;
            case (state)
                capture_pkg::uart_idle: begin
                    timer <= '0;
                    if (!rxd_sync) begin
                        state <= capture_pkg::uart_start;
                    end
                end
                capture_pkg::uart_start: begin
                    // middle of the start bit, a glitch returns to idle.
                    if (timer == capture_pkg::bit_cnt_t'(capture_pkg::clks_per_bit / 2 - 1)) begin
                        timer   <= '0;
                        bit_idx <= 3'd0;
                        state   <= rxd_sync ? capture_pkg::uart_idle : capture_pkg::uart_data;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                capture_pkg::uart_data: begin
                    if (bit_end) begin
                        timer   <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= capture_pkg::uart_stop;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                capture_pkg::uart_stop: begin
                    if (bit_end) begin
                        timer       <= '0;
                        capture_cmd <= rxd_sync && shreg == capture_pkg::cmd_capture;
                        readout_cmd <= rxd_sync && shreg == capture_pkg::cmd_readout;
                        state       <= capture_pkg::uart_idle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= capture_pkg::uart_idle;
                end
            endcase
        end
    end

    // data bits arrive lsb first.
    always_ff @(posedge clk) begin
        if (state == capture_pkg::uart_data && bit_end) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the frame capture testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_frame_capture -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_frame_capture)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "pass message missing from simulation output"
exit 1

/* verif/tb_frame_capture.sv */
// Directed testbench for the frame capture top level.
// Clock and reset, UART and video drivers, output stream collection,
// typed compare tasks and the directed tests.
`default_nettype none

module tb_frame_capture;

    localparam int stream_bytes = capture_pkg::frame_pixels * 3;
    localparam int byte_timeout = 200;
    localparam int ready_timeout = 200;

    logic                clk;
    logic                rst_n;
    logic                uart_rxd;
    logic                vsync;
    logic                de;
    capture_pkg::pixel_t pixel;
    logic                tx_ready;
    logic                tx_valid;
    capture_pkg::byte_t  tx_byte;
    logic                tx_last;
    logic                frame_ready;

    capture_pkg::pixel_t sent_frame [capture_pkg::frame_pixels];
    capture_pkg::pixel_t expected_frame [capture_pkg::frame_pixels];
    capture_pkg::byte_t  got_stream [stream_bytes];
    capture_pkg::byte_t  first_stream [stream_bytes];

    frame_capture_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rxd    (uart_rxd),
        .vsync       (vsync),
        .de          (de),
        .pixel       (pixel),
        .tx_ready    (tx_ready),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .tx_last     (tx_last),
        .frame_ready (frame_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s at time %0t", what, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input int idx, input capture_pkg::byte_t actual,
                              input capture_pkg::byte_t expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("byte %0d is %h, expected %h", idx, actual, expected));
        end
    endtask

    task automatic check_pixel(input int idx, input capture_pkg::pixel_t actual,
                               input capture_pkg::pixel_t expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("pixel %0d is %h, expected %h", idx, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, actual, expected));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // start bit, eight data bits lsb first, stop bit.
    task automatic send_uart_byte(input capture_pkg::byte_t data);
        uart_rxd = 1'b0;
        wait_cycles(capture_pkg::clks_per_bit);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = data[i];
            wait_cycles(capture_pkg::clks_per_bit);
        end
        uart_rxd = 1'b1;
        wait_cycles(capture_pkg::clks_per_bit);
    endtask

    // active pixels with vsync low, nothing armed to take them.
    task automatic send_stray_pixels(input int count);
        for (int i = 0; i < count; i++) begin
            de = 1'b1;
            pixel = capture_pkg::pixel_t'($urandom);
            wait_cycles(1);
        end
        de = 1'b0;
        wait_cycles(2);
    endtask

    task automatic send_frame();
        int gap;
        vsync = 1'b1;
        wait_cycles(3);
        vsync = 1'b0;
        wait_cycles(2);
        for (int i = 0; i < capture_pkg::frame_pixels; i++) begin
            gap = $urandom % 3;
            de = 1'b0;
            wait_cycles(gap);
            de = 1'b1;
            pixel = capture_pkg::pixel_t'($urandom);
            sent_frame[i] = pixel;
            wait_cycles(1);
        end
        de = 1'b0;
        pixel = '0;
    endtask

    task automatic wait_frame_ready();
        int count;
        count = 0;
        while (!frame_ready) begin
            if (count == ready_timeout) begin
                report_timeout("frame_ready");
            end
            count++;
            wait_cycles(1);
        end
    endtask

    // tx_ready is set before sampling, so a byte seen with both high moves on the next edge.
    task automatic read_frame(input bit drop_ready);
        int n;
        int idle;
        n = 0;
        idle = 0;
        while (n < stream_bytes) begin
            @(negedge clk);
            tx_ready = drop_ready ? (($urandom % 4) != 0) : 1'b1;
            if (tx_valid && tx_ready) begin
                got_stream[n] = tx_byte;
                check_flag("tx_last", tx_last, n == stream_bytes - 1);
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > byte_timeout) begin
                    report_timeout($sformatf("output byte %0d", n));
                end
            end
        end
        @(negedge clk);
        tx_ready = 1'b0;
        check_flag("tx_valid after last byte", tx_valid, 1'b0);
    endtask

    task automatic check_stream_pixels();
        capture_pkg::pixel_t got;
        for (int i = 0; i < capture_pkg::frame_pixels; i++) begin
            got = {got_stream[3 * i], got_stream[3 * i + 1], got_stream[3 * i + 2]};
            check_pixel(i, got, expected_frame[i]);
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 20; i++) begin
            wait_cycles(1);
            check_flag("frame_ready after reset", frame_ready, 1'b0);
            check_flag("tx_valid after reset", tx_valid, 1'b0);
        end
    endtask

    task automatic test_capture();
        send_uart_byte(8'h43);
        // a full frame's worth, enough to raise frame_ready if they were taken.
        send_stray_pixels(capture_pkg::frame_pixels);
        check_flag("frame_ready before vsync", frame_ready, 1'b0);
        send_frame();
        wait_frame_ready();
        expected_frame = sent_frame;
    endtask

    task automatic test_readout();
        send_uart_byte(8'h52);
        read_frame(1'b0);
        check_stream_pixels();
        first_stream = got_stream;
    endtask

    task automatic test_backpressure();
        send_uart_byte(8'h52);
        read_frame(1'b1);
        for (int i = 0; i < stream_bytes; i++) begin
            check_byte(i, got_stream[i], first_stream[i]);
        end
    endtask

    task automatic test_ignored_commands();
        // unknown command byte.
        send_uart_byte(8'h58);
        for (int i = 0; i < 50; i++) begin
            wait_cycles(1);
            check_flag("tx_valid after unknown byte", tx_valid, 1'b0);
            check_flag("frame_ready after unknown byte", frame_ready, 1'b1);
        end
        // a frame without a capture command.
        send_frame();
        wait_cycles(10);
        check_flag("frame_ready after unarmed frame", frame_ready, 1'b1);
        send_uart_byte(8'h52);
        read_frame(1'b0);
        check_stream_pixels();
        check_flag("frame_ready after second readout", frame_ready, 1'b1);
    endtask

    task automatic test_recapture();
        send_uart_byte(8'h43);
        check_flag("frame_ready after new capture", frame_ready, 1'b0);
        send_frame();
        wait_frame_ready();
        expected_frame = sent_frame;
        send_uart_byte(8'h52);
        read_frame(1'b1);
        check_stream_pixels();
    endtask

    initial begin
        void'($urandom(95270));
        rst_n = 1'b0;
        uart_rxd = 1'b1;
        vsync = 1'b0;
        de = 1'b0;
        pixel = '0;
        tx_ready = 1'b0;
        wait_cycles(5);
        rst_n = 1'b1;

        test_reset_idle();
        test_capture();
        test_readout();
        test_backpressure();
        test_ignored_commands();
        test_recapture();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
